// File: mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// byte address width
`define MEM_ADDR_W 32

// sram word, one doubleword
`define MEM_DATA_W 64

// one strobe bit per byte lane
`define MEM_STRB_W (`MEM_DATA_W / 8)

// byte offset bits inside a word
`define MEM_OFFS_W 3

// instruction width, half a word
`define MEM_INST_W 32

// 256 words, 2 KiB
`define MEM_DEPTH_LOG2 8

// first fetch address after reset
`define MEM_RESET_PC 32'h0000_0100

`endif

// File: mem_pkg.sv
`include "mem_defines.svh"

package mem_pkg;

	// plain vectors for the widths that carry a meaning
	typedef logic [`MEM_ADDR_W-1:0] addr_t;
	typedef logic [`MEM_DATA_W-1:0] word_t;
	typedef logic [`MEM_INST_W-1:0] inst_t;
	typedef logic [`MEM_STRB_W-1:0] strb_t;

	// access size, log2 of the byte count
	typedef enum logic [1:0] {
		size_b = 2'd0,
		size_h = 2'd1,
		size_w = 2'd2,
		size_d = 2'd3
	} mem_size_e;

	// who owns the sram channels
	typedef enum logic [1:0] {arb_idle, arb_ifu_busy, arb_lsu_busy} arb_state_e;

	// fetch sequencing
	typedef enum logic [1:0] {fetch_idle, fetch_req, fetch_wait, fetch_hold} fetch_state_e;

	// load/store sequencing
	typedef enum logic [1:0] {lsu_idle, lsu_req, lsu_wait, lsu_done} lsu_state_e;

endpackage

// File: mem_sram.sv
`timescale 1ns/1ns
`include "mem_defines.svh"

module mem_sram (
	input  logic           clk,
	input  logic           rst,
	// read address
	input  logic           arvalid,
	input  mem_pkg::addr_t araddr,
	output logic           arready,
	// read data
	output logic           rvalid,
	output mem_pkg::word_t rdata,
	output logic [1:0]     rresp,
	input  logic           rready,
	// write address and data
	input  logic           awvalid,
	input  mem_pkg::addr_t awaddr,
	input  mem_pkg::word_t wdata,
	input  mem_pkg::strb_t wstrb,
	output logic           awready,
	// write response
	output logic           bvalid,
	input  logic           bready
);
	import mem_pkg::*;

	// doubleword storage, contents survive reset
	word_t mem_q [0:(1 << `MEM_DEPTH_LOG2)-1];

	logic [`MEM_DEPTH_LOG2-1:0] rd_idx;
	logic [`MEM_DEPTH_LOG2-1:0] wr_idx;
	logic busy;
	logic rd_fire;
	logic wr_fire;

	// word index, upper address bits ignored
	assign rd_idx = araddr[`MEM_OFFS_W +: `MEM_DEPTH_LOG2];
	assign wr_idx = awaddr[`MEM_OFFS_W +: `MEM_DEPTH_LOG2];

	// one response in flight at most
	assign busy = rvalid | bvalid;
	assign arready = ~busy;
	// reads win a tie with writes
	assign awready = ~busy & ~arvalid;

	assign rd_fire = arvalid & arready;
	assign wr_fire = awvalid & awready;

	// always OKAY
	assign rresp = 2'b00;

	// response flags
	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (rd_fire) begin
				rvalid <= 1'b1;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
			if (wr_fire) begin
				bvalid <= 1'b1;
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	// registered read, byte-strobed write
	always_ff @(posedge clk) begin
		if (rd_fire) begin
			rdata <= mem_q[rd_idx];
		end
		if (wr_fire) begin
			for (int i = 0; i < `MEM_STRB_W; i++) begin
				// only strobed lanes change
				if (wstrb[i]) begin
					mem_q[wr_idx][8*i +: 8] <= wdata[8*i +: 8];
				end
			end
		end
	end

endmodule

// File: mem_arbiter.sv
`timescale 1ns/1ns
`include "mem_defines.svh"

module mem_arbiter (
	input  logic           clk,
	input  logic           rst,
	// fetch unit side
	input  logic           ifu_arvalid,
	input  mem_pkg::addr_t ifu_araddr,
	output logic           ifu_arready,
	output logic           ifu_rvalid,
	output mem_pkg::word_t ifu_rdata,
	input  logic           ifu_rready,
	// load/store unit side
	input  logic           lsu_arvalid,
	input  mem_pkg::addr_t lsu_araddr,
	output logic           lsu_arready,
	input  logic           lsu_awvalid,
	input  mem_pkg::addr_t lsu_awaddr,
	input  mem_pkg::word_t lsu_wdata,
	input  mem_pkg::strb_t lsu_wstrb,
	output logic           lsu_awready,
	output logic           lsu_rvalid,
	output mem_pkg::word_t lsu_rdata,
	input  logic           lsu_rready,
	output logic           lsu_bvalid,
	input  logic           lsu_bready,
	// sram side
	output logic           s_arvalid,
	output mem_pkg::addr_t s_araddr,
	input  logic           s_arready,
	input  logic           s_rvalid,
	input  mem_pkg::word_t s_rdata,
	output logic           s_rready,
	output logic           s_awvalid,
	output mem_pkg::addr_t s_awaddr,
	output mem_pkg::word_t s_wdata,
	output mem_pkg::strb_t s_wstrb,
	input  logic           s_awready,
	input  logic           s_bvalid,
	output logic           s_bready
);
	import mem_pkg::*;

	arb_state_e state_q;
	arb_state_e state_d;
	// set when the lsu was granted last
	logic last_lsu_q;
	logic ifu_want;
	logic lsu_want;
	logic gnt_ifu;
	logic gnt_lsu;
	logic addr_fire;
	logic resp_fire;

	assign ifu_want = ifu_arvalid;
	assign lsu_want = lsu_arvalid | lsu_awvalid;

	// grant decode, combinational in idle
	always_comb begin
		gnt_ifu = 1'b0;
		gnt_lsu = 1'b0;
		case (state_q)
			arb_idle: begin
				if (ifu_want && lsu_want) begin
					// both asking, serve the other one
					gnt_ifu = last_lsu_q;
					gnt_lsu = ~last_lsu_q;
				end else begin
					gnt_ifu = ifu_want;
					gnt_lsu = lsu_want;
				end
			end
			arb_ifu_busy: gnt_ifu = 1'b1;
			arb_lsu_busy: gnt_lsu = 1'b1;
			default: ;
		endcase
	end

	// request mux toward the sram
	assign s_arvalid = gnt_ifu ? ifu_arvalid : (gnt_lsu & lsu_arvalid);
	assign s_araddr  = gnt_lsu ? lsu_araddr : ifu_araddr;
	// only the lsu writes
	assign s_awvalid = gnt_lsu & lsu_awvalid;
	assign s_awaddr  = lsu_awaddr;
	assign s_wdata   = lsu_wdata;
	assign s_wstrb   = lsu_wstrb;
	assign s_rready  = gnt_ifu ? ifu_rready : (gnt_lsu & lsu_rready);
	assign s_bready  = gnt_lsu & lsu_bready;

	// responses and readies back to the winner, loser sees zeros
	assign ifu_arready = gnt_ifu & s_arready;
	assign ifu_rvalid  = gnt_ifu & s_rvalid;
	assign ifu_rdata   = s_rdata;
	assign lsu_arready = gnt_lsu & s_arready;
	assign lsu_awready = gnt_lsu & s_awready;
	assign lsu_rvalid  = gnt_lsu & s_rvalid;
	assign lsu_bvalid  = gnt_lsu & s_bvalid;
	assign lsu_rdata   = s_rdata;

	assign addr_fire = (s_arvalid & s_arready) | (s_awvalid & s_awready);
	assign resp_fire = (s_rvalid & s_rready) | (s_bvalid & s_bready);

	// ownership held from address transfer to response transfer
	always_comb begin
		state_d = state_q;
		case (state_q)
			arb_idle: begin
				if (addr_fire) begin
					state_d = gnt_lsu ? arb_lsu_busy : arb_ifu_busy;
				end
			end
			arb_ifu_busy, arb_lsu_busy: begin
				if (resp_fire) begin
					state_d = arb_idle;
				end
			end
			default: state_d = arb_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= arb_idle;
			last_lsu_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// remember the winner for round robin
			if (state_q == arb_idle && addr_fire) begin
				last_lsu_q <= gnt_lsu;
			end
		end
	end

endmodule

// File: fetch_unit.sv
`timescale 1ns/1ns
`include "mem_defines.svh"

module fetch_unit (
	input  logic           clk,
	input  logic           rst,
	input  logic           fetch_en,
	input  logic           redirect_valid,
	input  mem_pkg::addr_t redirect_pc,
	// memory side
	output logic           arvalid,
	output mem_pkg::addr_t araddr,
	input  logic           arready,
	input  logic           rvalid,
	input  mem_pkg::word_t rdata,
	output logic           rready,
	// instruction out
	output logic           inst_valid,
	output mem_pkg::addr_t inst_pc,
	output mem_pkg::inst_t inst,
	input  logic           inst_ready
);
	import mem_pkg::*;

	fetch_state_e state_q;
	addr_t pc_q;
	inst_t inst_q;
	// redirect seen while a request was in flight
	logic redir_q;
	addr_t redir_pc_q;
	logic redir_now;
	addr_t redir_tgt;
	fetch_state_e resume;

	// a live redirect beats a recorded one
	assign redir_now = redirect_valid | redir_q;
	assign redir_tgt = redirect_valid ? redirect_pc : redir_pc_q;
	assign resume = fetch_en ? fetch_req : fetch_idle;

	assign arvalid = (state_q == fetch_req);
	assign araddr = pc_q;
	assign rready = (state_q == fetch_wait);
	assign inst_valid = (state_q == fetch_hold);
	assign inst_pc = pc_q;
	assign inst = inst_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= fetch_idle;
			pc_q <= `MEM_RESET_PC;
			redir_q <= 1'b0;
		end else begin
			case (state_q)
				fetch_idle: begin
					// nothing outstanding, redirect applies at once
					if (redir_now) begin
						pc_q <= redir_tgt;
						redir_q <= 1'b0;
					end
					state_q <= resume;
				end
				fetch_req: begin
					// request must stay stable, just note the redirect
					if (redirect_valid) begin
						redir_q <= 1'b1;
						redir_pc_q <= redirect_pc;
					end
					if (arready) begin
						state_q <= fetch_wait;
					end
				end
				fetch_wait: begin
					if (rvalid && redir_now) begin
						// stale response, drop it
						pc_q <= redir_tgt;
						redir_q <= 1'b0;
						state_q <= resume;
					end else if (rvalid) begin
						state_q <= fetch_hold;
					end else if (redirect_valid) begin
						redir_q <= 1'b1;
						redir_pc_q <= redirect_pc;
					end
				end
				fetch_hold: begin
					// flush the held instruction on redirect
					if (redir_now) begin
						pc_q <= redir_tgt;
						redir_q <= 1'b0;
						state_q <= resume;
					end else if (inst_ready) begin
						pc_q <= pc_q + addr_t'(4);
						state_q <= resume;
					end
				end
				default: state_q <= fetch_idle;
			endcase
		end
	end

	// pc bit 2 picks the upper half
	always_ff @(posedge clk) begin
		if (state_q == fetch_wait && rvalid) begin
			inst_q <= pc_q[2] ? rdata[`MEM_INST_W +: `MEM_INST_W] : rdata[`MEM_INST_W-1:0];
		end
	end

endmodule

// File: lsu.sv
`timescale 1ns/1ns
`include "mem_defines.svh"

module lsu (
	input  logic              clk,
	input  logic              rst,
	// command port
	input  logic              cmd_valid,
	output logic              cmd_ready,
	input  logic              cmd_write,
	input  mem_pkg::mem_size_e cmd_size,
	input  mem_pkg::addr_t    cmd_addr,
	input  mem_pkg::word_t    cmd_wdata,
	output logic              resp_valid,
	output mem_pkg::word_t    resp_rdata,
	input  logic              resp_ready,
	// memory side
	output logic              arvalid,
	output mem_pkg::addr_t    araddr,
	input  logic              arready,
	input  logic              rvalid,
	input  mem_pkg::word_t    rdata,
	output logic              rready,
	output logic              awvalid,
	output mem_pkg::addr_t    awaddr,
	output mem_pkg::word_t    wdata,
	output mem_pkg::strb_t    wstrb,
	input  logic              awready,
	input  logic              bvalid,
	output logic              bready
);
	import mem_pkg::*;

	lsu_state_e state_q;
	logic write_q;
	mem_size_e size_q;
	addr_t addr_q;
	word_t wdata_q;
	strb_t wstrb_q;
	word_t rdata_q;
	word_t lane_data;
	strb_t base_strb;
	word_t ld_shift;
	word_t ld_data;
	logic [`MEM_OFFS_W-1:0] ld_off;

	// byte offset aligned down to the access size
	function automatic logic [`MEM_OFFS_W-1:0] lane_off(addr_t a, mem_size_e s);
		logic [`MEM_OFFS_W-1:0] keep;
		case (s)
			size_b: keep = 3'b111;
			size_h: keep = 3'b110;
			size_w: keep = 3'b100;
			default: keep = 3'b000;
		endcase
		return a[`MEM_OFFS_W-1:0] & keep;
	endfunction

	// store data copied into every lane, strobe picks the right one
	always_comb begin
		case (cmd_size)
			size_b: begin
				lane_data = {8{cmd_wdata[7:0]}};
				base_strb = 8'h01;
			end
			size_h: begin
				lane_data = {4{cmd_wdata[15:0]}};
				base_strb = 8'h03;
			end
			size_w: begin
				lane_data = {2{cmd_wdata[31:0]}};
				base_strb = 8'h0f;
			end
			default: begin
				lane_data = cmd_wdata;
				base_strb = 8'hff;
			end
		endcase
	end

	// load lane moved to bit 0, then zero-extended
	assign ld_off = lane_off(addr_q, size_q);
	assign ld_shift = rdata >> {ld_off, 3'b000};
	always_comb begin
		case (size_q)
			size_b: ld_data = word_t'(ld_shift[7:0]);
			size_h: ld_data = word_t'(ld_shift[15:0]);
			size_w: ld_data = word_t'(ld_shift[31:0]);
			default: ld_data = ld_shift;
		endcase
	end

	assign cmd_ready = (state_q == lsu_idle);
	assign arvalid = (state_q == lsu_req) & ~write_q;
	assign awvalid = (state_q == lsu_req) & write_q;
	assign araddr = addr_q;
	assign awaddr = addr_q;
	assign wdata = wdata_q;
	assign wstrb = wstrb_q;
	assign rready = (state_q == lsu_wait) & ~write_q;
	assign bready = (state_q == lsu_wait) & write_q;
	assign resp_valid = (state_q == lsu_done);
	assign resp_rdata = rdata_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= lsu_idle;
		end else begin
			case (state_q)
				lsu_idle: if (cmd_valid) state_q <= lsu_req;
				lsu_req: if ((arvalid && arready) || (awvalid && awready)) state_q <= lsu_wait;
				lsu_wait: if ((rvalid && rready) || (bvalid && bready)) state_q <= lsu_done;
				lsu_done: if (resp_ready) state_q <= lsu_idle;
				default: state_q <= lsu_idle;
			endcase
		end
	end

	// command capture and response data
	always_ff @(posedge clk) begin
		if (state_q == lsu_idle && cmd_valid) begin
			write_q <= cmd_write;
			size_q <= cmd_size;
			addr_q <= cmd_addr;
			wdata_q <= lane_data;
			wstrb_q <= base_strb << lane_off(cmd_addr, cmd_size);
		end
		if (rvalid && rready) begin
			rdata_q <= ld_data;
		end else if (bvalid && bready) begin
			// stores answer with zero
			rdata_q <= '0;
		end
	end

endmodule

// File: mem_top.sv
`timescale 1ns/1ns
`include "mem_defines.svh"

module mem_top (
	input  logic               clk,
	input  logic               rst,
	// fetch control and instruction stream
	input  logic               fetch_en,
	input  logic               redirect_valid,
	input  mem_pkg::addr_t     redirect_pc,
	output logic               inst_valid,
	output mem_pkg::addr_t     inst_pc,
	output mem_pkg::inst_t     inst,
	input  logic               inst_ready,
	// load/store commands
	input  logic               cmd_valid,
	output logic               cmd_ready,
	input  logic               cmd_write,
	input  mem_pkg::mem_size_e cmd_size,
	input  mem_pkg::addr_t     cmd_addr,
	input  mem_pkg::word_t     cmd_wdata,
	output logic               resp_valid,
	output mem_pkg::word_t     resp_rdata,
	input  logic               resp_ready
);
	import mem_pkg::*;

	// fetch unit to arbiter
	logic ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready;
	addr_t ifu_araddr;
	word_t ifu_rdata;
	// lsu to arbiter
	logic lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
	logic lsu_awvalid, lsu_awready, lsu_bvalid, lsu_bready;
	addr_t lsu_araddr;
	addr_t lsu_awaddr;
	word_t lsu_wdata;
	word_t lsu_rdata;
	strb_t lsu_wstrb;
	// arbiter to sram
	logic s_arvalid, s_arready, s_rvalid, s_rready;
	logic s_awvalid, s_awready, s_bvalid, s_bready;
	addr_t s_araddr;
	addr_t s_awaddr;
	word_t s_wdata;
	word_t s_rdata;
	strb_t s_wstrb;

	fetch_unit u_fetch_unit (
		.clk(clk), .rst(rst), .fetch_en(fetch_en),
		.redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
		.arvalid(ifu_arvalid), .araddr(ifu_araddr), .arready(ifu_arready),
		.rvalid(ifu_rvalid), .rdata(ifu_rdata), .rready(ifu_rready),
		.inst_valid(inst_valid), .inst_pc(inst_pc), .inst(inst), .inst_ready(inst_ready)
	);

	lsu u_lsu (
		.clk(clk), .rst(rst),
		.cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_write(cmd_write),
		.cmd_size(cmd_size), .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata),
		.resp_valid(resp_valid), .resp_rdata(resp_rdata), .resp_ready(resp_ready),
		.arvalid(lsu_arvalid), .araddr(lsu_araddr), .arready(lsu_arready),
		.rvalid(lsu_rvalid), .rdata(lsu_rdata), .rready(lsu_rready),
		.awvalid(lsu_awvalid), .awaddr(lsu_awaddr), .wdata(lsu_wdata),
		.wstrb(lsu_wstrb), .awready(lsu_awready),
		.bvalid(lsu_bvalid), .bready(lsu_bready)
	);

	mem_arbiter u_mem_arbiter (
		.clk(clk), .rst(rst),
		.ifu_arvalid(ifu_arvalid), .ifu_araddr(ifu_araddr), .ifu_arready(ifu_arready),
		.ifu_rvalid(ifu_rvalid), .ifu_rdata(ifu_rdata), .ifu_rready(ifu_rready),
		.lsu_arvalid(lsu_arvalid), .lsu_araddr(lsu_araddr), .lsu_arready(lsu_arready),
		.lsu_awvalid(lsu_awvalid), .lsu_awaddr(lsu_awaddr), .lsu_wdata(lsu_wdata),
		.lsu_wstrb(lsu_wstrb), .lsu_awready(lsu_awready),
		.lsu_rvalid(lsu_rvalid), .lsu_rdata(lsu_rdata), .lsu_rready(lsu_rready),
		.lsu_bvalid(lsu_bvalid), .lsu_bready(lsu_bready),
		.s_arvalid(s_arvalid), .s_araddr(s_araddr), .s_arready(s_arready),
		.s_rvalid(s_rvalid), .s_rdata(s_rdata), .s_rready(s_rready),
		.s_awvalid(s_awvalid), .s_awaddr(s_awaddr), .s_wdata(s_wdata),
		.s_wstrb(s_wstrb), .s_awready(s_awready),
		.s_bvalid(s_bvalid), .s_bready(s_bready)
	);

	// rresp is always OKAY, nothing consumes it
	mem_sram u_mem_sram (
		.clk(clk), .rst(rst),
		.arvalid(s_arvalid), .araddr(s_araddr), .arready(s_arready),
		.rvalid(s_rvalid), .rdata(s_rdata), .rresp(), .rready(s_rready),
		.awvalid(s_awvalid), .awaddr(s_awaddr), .wdata(s_wdata),
		.wstrb(s_wstrb), .awready(s_awready),
		.bvalid(s_bvalid), .bready(s_bready)
	);

endmodule

// File: tb_mem_model.svh
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

// reference copy of the sram contents
word_t ref_mem [0:(1 << `MEM_DEPTH_LOG2)-1];

// doubleword index with the address bits above it ignored
function automatic int word_index(input addr_t a);
	return int'(a[`MEM_OFFS_W +: `MEM_DEPTH_LOG2]);
endfunction

// first byte of the access with the offset rounded down to a multiple of the size
function automatic int first_byte(input addr_t a, input mem_size_e sz);
	int nbytes;
	nbytes = 1 << int'(sz);
	return (int'(a[`MEM_OFFS_W-1:0]) / nbytes) * nbytes;
endfunction

// store puts the low bytes of d in the addressed lane and keeps the other bytes
function automatic void ref_store(input addr_t a, input mem_size_e sz, input word_t d);
	int idx;
	int off;
	int nbytes;
	idx = word_index(a);
	off = first_byte(a, sz);
	nbytes = 1 << int'(sz);
	for (int i = 0; i < nbytes; i++) begin
		ref_mem[idx][8*(off+i) +: 8] = d[8*i +: 8];
	end
endfunction

// load gathers the lane bytes from bit 0 up and leaves the rest zero
function automatic word_t ref_load(input addr_t a, input mem_size_e sz);
	word_t v;
	int idx;
	int off;
	int nbytes;
	v = '0;
	idx = word_index(a);
	off = first_byte(a, sz);
	nbytes = 1 << int'(sz);
	for (int i = 0; i < nbytes; i++) begin
		v[8*i +: 8] = ref_mem[idx][8*(off+i) +: 8];
	end
	return v;
endfunction

// instruction half picked by pc bit 2
function automatic inst_t ref_inst(input addr_t pc);
	word_t w;
	w = ref_mem[word_index(pc)];
	return pc[2] ? w[63:32] : w[31:0];
endfunction

// 32-bit linear congruential step
function automatic logic [31:0] lcg_next(input logic [31:0] s);
	return s * 32'd1103515245 + 32'd12345;
endfunction

`endif

// File: tb_mem_top.sv
`timescale 1ns/1ns
`include "mem_defines.svh"

module tb_mem_top;
	import mem_pkg::*;

	`include "tb_mem_model.svh"

	localparam int DEPTH = 1 << `MEM_DEPTH_LOG2;
	// image writes plus dword pairs plus test 2 plus two mixed runs
	localparam int N_CMDS = DEPTH + 64 + 96 + 64;
	localparam int TIMEOUT_CYCLES = N_CMDS * 40 + 1000;

	logic clk;
	logic rst;
	logic fetch_en;
	logic redirect_valid;
	addr_t redirect_pc;
	logic inst_valid;
	addr_t inst_pc;
	inst_t inst;
	logic inst_ready = 1'b1;
	logic cmd_valid;
	logic cmd_ready;
	logic cmd_write;
	mem_size_e cmd_size;
	addr_t cmd_addr;
	word_t cmd_wdata;
	logic resp_valid;
	word_t resp_rdata;
	logic resp_ready = 1'b1;

	int errors = 0;
	int checks = 0;
	int inst_count = 0;
	// next pc the instruction stream must show
	addr_t exp_pc = `MEM_RESET_PC;
	// load/store responses in command order
	word_t exp_resp_q[$];
	logic stall_en = 1'b0;
	logic [31:0] seed = 32'd10;
	logic [31:0] stall_seed = 32'd10;

	mem_top u_mem_top (
		.clk(clk), .rst(rst),
		.fetch_en(fetch_en), .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
		.inst_valid(inst_valid), .inst_pc(inst_pc), .inst(inst), .inst_ready(inst_ready),
		.cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_write(cmd_write),
		.cmd_size(cmd_size), .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata),
		.resp_valid(resp_valid), .resp_rdata(resp_rdata), .resp_ready(resp_ready)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// upper halves of two lcg steps since the low lcg bits repeat too soon
	function automatic logic [31:0] next_rand();
		logic [31:0] s1;
		seed = lcg_next(seed);
		s1 = seed;
		seed = lcg_next(seed);
		return {s1[31:16], seed[31:16]};
	endfunction

	function automatic word_t random_word();
		logic [31:0] hi;
		hi = next_rand();
		return {hi, next_rand()};
	endfunction

	// called 10 ns after a rising edge and returns the same way
	task automatic issue_cmd(input logic wr, input mem_size_e sz, input addr_t a,
			input word_t d);
		cmd_valid = 1'b1;
		cmd_write = wr;
		cmd_size = sz;
		cmd_addr = a;
		cmd_wdata = d;
		@(negedge clk);
		while (!cmd_ready) @(negedge clk);
		// accepted at the coming edge once earlier commands are all done
		if (wr) begin
			ref_store(a, sz, d);
			exp_resp_q.push_back('0);
		end else begin
			exp_resp_q.push_back(ref_load(a, sz));
		end
		@(posedge clk);
		#10;
		cmd_valid = 1'b0;
	endtask

	task automatic drain_resps();
		do @(posedge clk); while (exp_resp_q.size() != 0);
		#10;
	endtask

	task automatic wait_insts(input int n);
		int target;
		target = inst_count + n;
		while (inst_count < target) @(posedge clk);
		#10;
	endtask

	// mixed loads and stores with addresses limited by mask
	task automatic random_cmds(input int n, input addr_t mask);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			r = next_rand();
			issue_cmd(r[31], mem_size_e'(r[30:29]), next_rand() & mask, random_word());
		end
		drain_resps();
	endtask

	task automatic report_and_finish();
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	endtask

	// random back-pressure on both consumer readies
	always @(posedge clk) begin
		#10;
		if (stall_en) begin
			stall_seed = lcg_next(stall_seed);
			inst_ready = stall_seed[30];
			resp_ready = stall_seed[27];
		end else begin
			inst_ready = 1'b1;
			resp_ready = 1'b1;
		end
	end

	// negedge sees the same valid and ready as the next rising edge
	always @(negedge clk) begin
		word_t exp_word;
		inst_t exp_inst;
		if (!rst) begin
			if (resp_valid && resp_ready) begin
				checks++;
				if (exp_resp_q.size() == 0) begin
					errors++;
					$display("at %0t a response came with no command outstanding", $time);
				end else begin
					exp_word = exp_resp_q.pop_front();
					if (resp_rdata !== exp_word) begin
						errors++;
						$display("MISMATCH at %0t: resp_rdata expected %h seen %h",
							$time, exp_word, resp_rdata);
					end
				end
			end
			if (inst_valid && inst_ready) begin
				checks++;
				exp_inst = ref_inst(exp_pc);
				if (inst_pc !== exp_pc || inst !== exp_inst) begin
					errors++;
					$display("MISMATCH at %0t: inst expected pc %h inst %h seen pc %h inst %h",
						$time, exp_pc, exp_inst, inst_pc, inst);
				end
				exp_pc = exp_pc + 32'd4;
				inst_count++;
			end
			// old stream ends at this edge
			if (redirect_valid) begin
				exp_pc = redirect_pc;
			end
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		errors++;
		$display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
		report_and_finish();
	end

	initial begin
		logic [31:0] r;
		addr_t saved [0:31];
		int base;
		rst = 1'b1;
		fetch_en = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		cmd_valid = 1'b0;
		cmd_write = 1'b0;
		cmd_size = size_b;
		cmd_addr = '0;
		cmd_wdata = '0;
		repeat (4) @(posedge clk);
		#10;
		rst = 1'b0;

		// quiet outputs before any stimulus
		repeat (3) begin
			@(negedge clk);
			checks++;
			if (inst_valid || resp_valid) begin
				errors++;
				$display("at %0t a valid output was high after reset with no stimulus", $time);
			end
		end
		@(posedge clk);
		#10;

		// test 1 writes the whole image and then random dword store and load pairs
		for (int i = 0; i < DEPTH; i++) begin
			issue_cmd(1'b1, size_d, addr_t'(i * 8), random_word());
		end
		for (int i = 0; i < 32; i++) begin
			saved[i] = next_rand();
			issue_cmd(1'b1, size_d, saved[i], random_word());
		end
		for (int i = 0; i < 32; i++) begin
			issue_cmd(1'b0, size_d, saved[i], '0);
		end
		drain_resps();

		// test 2 merges narrow stores by strobe and loads every size
		for (int i = 0; i < 48; i++) begin
			r = next_rand();
			issue_cmd(1'b1, mem_size_e'(r[1:0]), next_rand(), random_word());
		end
		for (int i = 0; i < 48; i++) begin
			r = next_rand();
			issue_cmd(1'b0, mem_size_e'(r[1:0]), next_rand(), '0);
		end
		drain_resps();

		// test 3 fetches in order from the reset vector
		fetch_en = 1'b1;
		wait_insts(24);

		// test 4 runs fetch and commands together with stores below the fetch stream
		base = inst_count;
		random_cmds(32, 32'h0000_007f);
		checks++;
		if (inst_count - base < 8) begin
			errors++;
			$display("fetch starved, only %0d instructions during 32 commands",
				inst_count - base);
		end

		// test 6 redirects mid stream to an upper half target
		redirect_valid = 1'b1;
		redirect_pc = `MEM_RESET_PC + 32'h4;
		@(posedge clk);
		#10;
		redirect_valid = 1'b0;
		wait_insts(4);

		// test 5 adds random stalls on both outputs
		stall_en = 1'b1;
		random_cmds(32, 32'h0000_007f);
		wait_insts(8);
		stall_en = 1'b0;

		fetch_en = 1'b0;
		repeat (8) @(posedge clk);
		report_and_finish();
	end

endmodule

// File: build.f
+incdir+.
mem_pkg.sv
mem_sram.sv
mem_arbiter.sv
fetch_unit.sv
lsu.sv
mem_top.sv
tb_mem_top.sv

// File: Makefile
# Verilator flow for the memory subsystem
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_mem_top
RTL_TOP   ?= mem_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
